/* source/lspc_settings.svh */
`ifndef LSPC_SETTINGS_SVH
`define LSPC_SETTINGS_SVH

// Video geometry, in 24MHz clocks, pixels and lines
`define LSPC_CLKS_PER_PIXEL      4
`define LSPC_PIXELS_PER_LINE     384
`define LSPC_LINES_PER_FRAME     264
// Sync widths, sync is low from count 0
`define LSPC_HSYNC_PIXELS        29
`define LSPC_VSYNC_LINES         8
// Active window, bounds inclusive
`define LSPC_ACTIVE_PIXEL_FIRST  40
`define LSPC_ACTIVE_PIXEL_LAST   359
`define LSPC_ACTIVE_LINE_FIRST   16
`define LSPC_ACTIVE_LINE_LAST    239
// Line where the vblank interrupt fires
`define LSPC_VBLANK_IRQ_LINE     240

// CPU register window, word index
`define LSPC_REG_VRAMADDR        0
`define LSPC_REG_VRAMRW          1
`define LSPC_REG_VRAMMOD         2
`define LSPC_REG_MODE            3
`define LSPC_REG_TIMERHIGH       4
`define LSPC_REG_TIMERLOW        5
`define LSPC_REG_IRQACK          6

// Mode register fields
`define LSPC_MODE_TIMER_EN       4
`define LSPC_MODE_AA_LSB         8
`define LSPC_MODE_AA_MSB         15

// Acknowledge register bits
`define LSPC_ACK_VBLANK          2
`define LSPC_ACK_TIMER           1

`endif

/* source/lspcPkg.sv */
`default_nettype none

package lspcPkg;

	// CPU and VRAM data word
	typedef logic [15:0] word_t;
	// VRAM word address, full 64K range
	typedef logic [15:0] vramAddr_t;
	// Register select, CPU A3..A1
	typedef logic [2:0] regIndex_t;

	// Screen counters
	typedef logic [8:0] pixelCount_t;
	typedef logic [8:0] rasterCount_t;

	// Auto-animation tile number and frame divider
	typedef logic [2:0] aaCount_t;
	typedef logic [7:0] aaSpeed_t;

	typedef logic [31:0] timerCount_t;

	// 0 none, 1 vblank, 2 timer
	typedef logic [1:0] iplLevel_t;

	// Single-cycle CPU access, at most one strobe high
	typedef struct packed {
		logic we;
		logic re;
		regIndex_t index;
		word_t wData;
	} cpuReq_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank;
	} videoSync_t;

	// Load strobe, run enable and reload value
	typedef struct packed {
		logic load;
		logic enable;
		timerCount_t reload;
	} timerCtl_t;

endpackage

`default_nettype wire

/* source/videoTiming.sv */
`default_nettype none

`include "lspc_settings.svh"

module videoTiming (
	input wire clk24M,
	input wire rst,
	output logic pixelEn,
	output lspcPkg::rasterCount_t rasterCount,
	output logic frameStart,
	output lspcPkg::videoSync_t videoSync
);

	import lspcPkg::*;

	// 24MHz down to the 6MHz dot rate
	logic [1:0] prescaler;
	pixelCount_t pixelCount;
	logic lineEnd;
	logic frameEnd;
	logic hActive;
	logic vActive;

	// Registered enable, one clock in four
	always_ff @(posedge clk24M) begin
		if (rst) begin
			prescaler <= '0;
			pixelEn <= 1'b0;
		end else begin
			prescaler <= prescaler + 2'd1;
			pixelEn <= (prescaler == 2'(`LSPC_CLKS_PER_PIXEL - 1));
		end
	end

	assign lineEnd = (pixelCount == 9'(`LSPC_PIXELS_PER_LINE - 1));
	assign frameEnd = (rasterCount == 9'(`LSPC_LINES_PER_FRAME - 1));

	// Pixel counter, raster counter steps on its wrap
	always_ff @(posedge clk24M) begin
		if (rst) begin
			pixelCount <= '0;
			rasterCount <= '0;
		end else if (pixelEn) begin
			pixelCount <= lineEnd ? '0 : pixelCount + 9'd1;
			if (lineEnd)
				rasterCount <= frameEnd ? '0 : rasterCount + 9'd1;
		end
	end

	// Active windows
	assign hActive = (pixelCount >= 9'(`LSPC_ACTIVE_PIXEL_FIRST))
		&& (pixelCount <= 9'(`LSPC_ACTIVE_PIXEL_LAST));
	assign vActive = (rasterCount >= 9'(`LSPC_ACTIVE_LINE_FIRST))
		&& (rasterCount <= 9'(`LSPC_ACTIVE_LINE_LAST));

	// Sync levels, one clock behind the counters
	always_ff @(posedge clk24M) begin
		videoSync.hsync <= (pixelCount >= 9'(`LSPC_HSYNC_PIXELS));
		videoSync.vsync <= (rasterCount >= 9'(`LSPC_VSYNC_LINES));
		videoSync.blank <= !(hActive && vActive);
	end

	// Start of the vblank interrupt line, single clock
	assign frameStart = pixelEn && (pixelCount == '0)
		&& (rasterCount == 9'(`LSPC_VBLANK_IRQ_LINE));

endmodule

`default_nettype wire

/* source/cpuRegs.sv */
`default_nettype none

`include "lspc_settings.svh"

module cpuRegs (
	input wire clk24M,
	input wire rst,
	input wire lspcPkg::cpuReq_t cpuReq,
	output lspcPkg::word_t cpuRData,
	output lspcPkg::vramAddr_t vramAddr,
	output lspcPkg::word_t vramWData,
	output logic vramWe,
	input wire lspcPkg::word_t vramRData,
	input wire lspcPkg::rasterCount_t rasterCount,
	input wire lspcPkg::aaCount_t aaCount,
	output lspcPkg::aaSpeed_t aaSpeed,
	output lspcPkg::timerCtl_t timerCtl,
	output logic irqAck,
	output logic [1:0] irqAckBits
);

	import lspcPkg::*;

	// Write decode
	logic wrAddr;
	logic wrRw;
	logic wrMod;
	logic wrMode;
	logic wrTimerHigh;
	logic wrTimerLow;
	logic wrAck;

	// CPU-visible registers
	word_t regVramAddr;
	word_t regVramMod;
	word_t timerHigh;
	word_t timerLow;
	logic timerEn;
	logic timerLoad;

	vramAddr_t addrNext;
	word_t readMux;

	assign wrAddr = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_VRAMADDR));
	assign wrRw = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_VRAMRW));
	assign wrMod = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_VRAMMOD));
	assign wrMode = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_MODE));
	assign wrTimerHigh = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_TIMERHIGH));
	assign wrTimerLow = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_TIMERLOW));
	assign wrAck = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_IRQACK));

	// Address update mux
	// A new VRAMADDR wins over the post-write modulo step
	always_comb begin
		if (wrAddr)
			addrNext = cpuReq.wData;
		else if (vramWe)
			addrNext = vramAddr + regVramMod;
		else
			addrNext = vramAddr;
	end

	always_ff @(posedge clk24M) begin
		if (rst) begin
			regVramAddr <= '0;
			regVramMod <= '0;
			vramAddr <= '0;
			vramWe <= 1'b0;
			aaSpeed <= '0;
			timerEn <= 1'b0;
			timerHigh <= '0;
			timerLow <= '0;
			timerLoad <= 1'b0;
			irqAck <= 1'b0;
		end else begin
			vramAddr <= addrNext;
			// Write strobe for the cycle after VRAMRW
			vramWe <= wrRw;
			// Load once both halves are in place
			timerLoad <= wrTimerLow;
			irqAck <= wrAck;
			if (wrAddr)
				regVramAddr <= cpuReq.wData;
			if (wrMod)
				regVramMod <= cpuReq.wData;
			if (wrMode) begin
				aaSpeed <= cpuReq.wData[`LSPC_MODE_AA_MSB:`LSPC_MODE_AA_LSB];
				timerEn <= cpuReq.wData[`LSPC_MODE_TIMER_EN];
			end
			if (wrTimerHigh)
				timerHigh <= cpuReq.wData;
			if (wrTimerLow)
				timerLow <= cpuReq.wData;
		end
	end

	// Write data and ack bits, held with their strobes
	always_ff @(posedge clk24M) begin
		if (wrRw)
			vramWData <= cpuReq.wData;
		// Vblank in bit 1, timer in bit 0
		if (wrAck)
			irqAckBits <= {cpuReq.wData[`LSPC_ACK_VBLANK], cpuReq.wData[`LSPC_ACK_TIMER]};
	end

	assign timerCtl = '{load: timerLoad, enable: timerEn, reload: {timerHigh, timerLow}};

	// Read-back select
	always_comb begin
		case (cpuReq.index)
			regIndex_t'(`LSPC_REG_VRAMADDR): readMux = regVramAddr;
			regIndex_t'(`LSPC_REG_VRAMRW): readMux = vramRData;
			regIndex_t'(`LSPC_REG_VRAMMOD): readMux = regVramMod;
			// Raster line on top, tile number at the bottom
			regIndex_t'(`LSPC_REG_MODE): readMux = {rasterCount, 4'b0000, aaCount};
			default: readMux = '0;
		endcase
	end

	// Read data one cycle after the strobe
	always_ff @(posedge clk24M) begin
		if (cpuReq.re)
			cpuRData <= readMux;
	end

endmodule

`default_nettype wire

/* source/rasterTimer.sv */
`default_nettype none

module rasterTimer (
	input wire clk24M,
	input wire rst,
	input wire pixelEn,
	input wire lspcPkg::timerCtl_t timerCtl,
	output logic timerIrq
);

	import lspcPkg::*;

	// Pixel-rate down counter
	timerCount_t count;
	// Zero reached on a counting pixel
	logic expire;
	logic tick;

	// Counts only on enabled pixels
	assign tick = pixelEn && timerCtl.enable;
	assign expire = tick && (count == '0);

	// A load in the same cycle takes over
	assign timerIrq = expire && !timerCtl.load;

	always_ff @(posedge clk24M) begin
		if (rst) begin
			count <= '0;
		end else if (timerCtl.load) begin
			// CPU load, immediate
			count <= timerCtl.reload;
		end else if (expire) begin
			// Auto reload on underflow
			count <= timerCtl.reload;
		end else if (tick) begin
			count <= count - 32'd1;
		end
	end

	// Load of N gives N decrements then the pulse
	// so the pulse lands on pixel N+1

endmodule

`default_nettype wire

/* source/irqControl.sv */
`default_nettype none

module irqControl (
	input wire clk24M,
	input wire rst,
	input wire vblankIrq,
	input wire timerIrq,
	input wire irqAck,
	input wire [1:0] irqAckBits,
	output lspcPkg::iplLevel_t ipl
);

	import lspcPkg::*;

	logic vblankPend;
	logic timerPend;
	iplLevel_t iplNext;

	// Pending flags, a new pulse beats a same-cycle ack
	always_ff @(posedge clk24M) begin
		if (rst) begin
			vblankPend <= 1'b0;
			timerPend <= 1'b0;
			ipl <= '0;
		end else begin
			if (vblankIrq)
				vblankPend <= 1'b1;
			else if (irqAck && irqAckBits[1])
				vblankPend <= 1'b0;
			if (timerIrq)
				timerPend <= 1'b1;
			else if (irqAck && irqAckBits[0])
				timerPend <= 1'b0;
			ipl <= iplNext;
		end
	end

	// Timer over vblank
	assign iplNext = timerPend ? 2'd2 : (vblankPend ? 2'd1 : 2'd0);

endmodule

`default_nettype wire

/* source/autoAnim.sv */
`default_nettype none

module autoAnim (
	input wire clk24M,
	input wire rst,
	input wire frameStart,
	input wire lspcPkg::aaSpeed_t aaSpeed,
	output lspcPkg::aaCount_t aaCount
);

	import lspcPkg::*;

	// Frames since the last step
	aaSpeed_t frameDiv;
	logic step;

	// Speed S means a step every S+1 frames
	assign step = frameStart && (frameDiv == aaSpeed);

	always_ff @(posedge clk24M) begin
		if (rst) begin
			frameDiv <= '0;
			aaCount <= '0;
		end else if (step) begin
			frameDiv <= '0;
			// Tile number wraps at 8
			aaCount <= aaCount + 3'd1;
		end else if (frameStart) begin
			frameDiv <= frameDiv + 8'd1;
		end
	end

endmodule

`default_nettype wire

/* source/lspcTop.sv */
`default_nettype none

module lspcTop (
	input wire clk24M,
	input wire rst,
	input wire lspcPkg::cpuReq_t cpuReq,
	output lspcPkg::word_t cpuRData,
	output lspcPkg::vramAddr_t vramAddr,
	output lspcPkg::word_t vramWData,
	output logic vramWe,
	input wire lspcPkg::word_t vramRData,
	output lspcPkg::videoSync_t videoSync,
	output lspcPkg::iplLevel_t ipl
);

	import lspcPkg::*;

	// Video timing outputs
	logic pixelEn;
	logic frameStart;
	rasterCount_t rasterCount;

	// Register block to the other functions
	timerCtl_t timerCtl;
	aaSpeed_t aaSpeed;
	aaCount_t aaCount;
	logic irqAck;
	logic [1:0] irqAckBits;

	// Timer interrupt pulse
	logic timerIrq;

	videoTiming timing (
		.clk24M      (clk24M),
		.rst         (rst),
		.pixelEn     (pixelEn),
		.rasterCount (rasterCount),
		.frameStart  (frameStart),
		.videoSync   (videoSync)
	);

	cpuRegs regs (
		.clk24M      (clk24M),
		.rst         (rst),
		.cpuReq      (cpuReq),
		.cpuRData    (cpuRData),
		.vramAddr    (vramAddr),
		.vramWData   (vramWData),
		.vramWe      (vramWe),
		.vramRData   (vramRData),
		.rasterCount (rasterCount),
		.aaCount     (aaCount),
		.aaSpeed     (aaSpeed),
		.timerCtl    (timerCtl),
		.irqAck      (irqAck),
		.irqAckBits  (irqAckBits)
	);

	rasterTimer timer (
		.clk24M   (clk24M),
		.rst      (rst),
		.pixelEn  (pixelEn),
		.timerCtl (timerCtl),
		.timerIrq (timerIrq)
	);

	// Frame pulse doubles as the vblank interrupt
	irqControl irq (
		.clk24M     (clk24M),
		.rst        (rst),
		.vblankIrq  (frameStart),
		.timerIrq   (timerIrq),
		.irqAck     (irqAck),
		.irqAckBits (irqAckBits),
		.ipl        (ipl)
	);

	autoAnim anim (
		.clk24M     (clk24M),
		.rst        (rst),
		.frameStart (frameStart),
		.aaSpeed    (aaSpeed),
		.aaCount    (aaCount)
	);

endmodule

`default_nettype wire

/* bench/lspc_properties.sv */
`default_nettype none

`include "lspc_settings.svh"

module lspcProperties (
	input wire clk24M,
	input wire rst,
	input wire lspcPkg::cpuReq_t cpuReq,
	input wire lspcPkg::vramAddr_t vramAddr,
	input wire lspcPkg::word_t vramWData,
	input wire vramWe,
	input wire lspcPkg::videoSync_t videoSync,
	input wire lspcPkg::iplLevel_t ipl,
	input wire pixelEn,
	input wire frameStart,
	input wire lspcPkg::aaCount_t aaCount,
	input wire lspcPkg::aaSpeed_t aaSpeed
);
	timeunit 1ns;
	timeprecision 1ns;

	import lspcPkg::*;

	localparam int lineClks = `LSPC_CLKS_PER_PIXEL * `LSPC_PIXELS_PER_LINE;
	localparam int hsyncClks = `LSPC_HSYNC_PIXELS * `LSPC_CLKS_PER_PIXEL;
	localparam int activeClks =
		(`LSPC_ACTIVE_PIXEL_LAST - `LSPC_ACTIVE_PIXEL_FIRST + 1) * `LSPC_CLKS_PER_PIXEL;

	// Read by the testbench after each test
	int failCount = 0;

	logic rwWrite;
	logic addrWrite;
	logic ackTimer;
	logic expireNow;
	logic loadNow;
	logic enShadow;
	word_t modShadow;
	timerCount_t reloadShadow;
	timerCount_t pixCnt;
	// Run lengths of the sync levels
	int hLow;
	int hHigh;
	int vLow;
	int bLow;
	logic hArmed;
	logic vArmed;
	logic bArmed;
	aaCount_t aaPrev;
	int aaFrames;

	assign rwWrite = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_VRAMRW));
	assign addrWrite = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_VRAMADDR));
	assign ackTimer = cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_IRQACK))
		&& cpuReq.wData[`LSPC_ACK_TIMER];
	// Enabled pixel number N+1 after a load of N
	assign expireNow = pixelEn && enShadow && !loadNow && (pixCnt == reloadShadow);

	// Register copies seen from the CPU side
	always_ff @(posedge clk24M) begin
		if (rst) begin
			modShadow <= '0;
			enShadow <= 1'b0;
			reloadShadow <= '0;
			loadNow <= 1'b0;
			pixCnt <= '0;
		end else begin
			loadNow <= cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_TIMERLOW));
			if (cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_VRAMMOD)))
				modShadow <= cpuReq.wData;
			if (cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_MODE)))
				enShadow <= cpuReq.wData[`LSPC_MODE_TIMER_EN];
			if (cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_TIMERHIGH)))
				reloadShadow[31:16] <= cpuReq.wData;
			if (cpuReq.we && (cpuReq.index == regIndex_t'(`LSPC_REG_TIMERLOW)))
				reloadShadow[15:0] <= cpuReq.wData;
			if (loadNow || expireNow)
				pixCnt <= '0;
			else if (pixelEn && enShadow)
				pixCnt <= pixCnt + 32'd1;
		end
	end

	// Runs are only judged once a full run has been seen
	always_ff @(posedge clk24M) begin
		if (rst) begin
			hLow <= 0;
			hHigh <= 0;
			vLow <= 0;
			bLow <= 0;
			hArmed <= 1'b0;
			vArmed <= 1'b0;
			bArmed <= 1'b0;
			aaPrev <= '0;
			aaFrames <= 0;
		end else begin
			hLow <= videoSync.hsync ? 0 : hLow + 1;
			hHigh <= videoSync.hsync ? hHigh + 1 : 0;
			vLow <= videoSync.vsync ? 0 : vLow + 1;
			bLow <= videoSync.blank ? 0 : bLow + 1;
			hArmed <= hArmed || videoSync.hsync;
			vArmed <= vArmed || videoSync.vsync;
			bArmed <= bArmed || videoSync.blank;
			aaPrev <= aaCount;
			// Frames since the last tile step
			if (aaCount != aaPrev)
				aaFrames <= 0;
			else if (frameStart)
				aaFrames <= aaFrames + 1;
		end
	end

	assert property (@(posedge clk24M) disable iff (rst) vramWe == $past(rwWrite))
	else begin
		failCount++;
		$error("vramWe does not follow the VRAMRW write by one clock");
	end

	assert property (@(posedge clk24M) disable iff (rst)
		rwWrite |=> (vramWData == $past(cpuReq.wData)) && (vramAddr == $past(vramAddr)))
	else begin
		failCount++;
		$error("VRAM write carries the wrong word or address");
	end

	// Modulo step after each write
	assert property (@(posedge clk24M) disable iff (rst)
		(vramWe && !addrWrite) |=> vramAddr == 16'($past(vramAddr) + $past(modShadow)))
	else begin
		failCount++;
		$error("VRAM address did not advance by the modulo");
	end

	assert property (@(posedge clk24M) disable iff (rst)
		($rose(videoSync.hsync) && hArmed) |-> hLow == hsyncClks)
	else begin
		failCount++;
		$error("hsync low for %0d clocks", hLow);
	end

	assert property (@(posedge clk24M) disable iff (rst)
		($fell(videoSync.hsync) && hArmed) |-> hHigh == lineClks - hsyncClks)
	else begin
		failCount++;
		$error("hsync high for %0d clocks", hHigh);
	end

	assert property (@(posedge clk24M) disable iff (rst)
		($rose(videoSync.vsync) && vArmed) |-> vLow == `LSPC_VSYNC_LINES * lineClks)
	else begin
		failCount++;
		$error("vsync low for %0d clocks", vLow);
	end

	// Active area sits inside both sync high windows
	assert property (@(posedge clk24M) disable iff (rst)
		!videoSync.blank |-> videoSync.hsync && videoSync.vsync)
	else begin
		failCount++;
		$error("blank low during a sync pulse");
	end

	assert property (@(posedge clk24M) disable iff (rst)
		($rose(videoSync.blank) && bArmed) |-> bLow == activeClks)
	else begin
		failCount++;
		$error("blank low for %0d clocks in a line", bLow);
	end

	assert property (@(posedge clk24M) disable iff (rst)
		$changed(aaCount) |-> (aaCount == 3'($past(aaCount) + 1))
			&& (aaFrames == int'(aaSpeed) + 1))
	else begin
		failCount++;
		$error("auto-animation stepped after %0d frames", aaFrames);
	end

	assert property (@(posedge clk24M) disable iff (rst)
		$rose(ipl == 2'd2) |-> $past(expireNow, 2))
	else begin
		failCount++;
		$error("timer interrupt without an expiry of the enabled timer");
	end

	assert property (@(posedge clk24M) disable iff (rst) ackTimer |-> ##3 (ipl != 2'd2))
	else begin
		failCount++;
		$error("timer interrupt still raised after its acknowledge");
	end

endmodule

bind lspcTop lspcProperties props (
	.clk24M     (clk24M),
	.rst        (rst),
	.cpuReq     (cpuReq),
	.vramAddr   (vramAddr),
	.vramWData  (vramWData),
	.vramWe     (vramWe),
	.videoSync  (videoSync),
	.ipl        (ipl),
	.pixelEn    (pixelEn),
	.frameStart (frameStart),
	.aaCount    (aaCount),
	.aaSpeed    (aaSpeed)
);

`default_nettype wire

/* bench/lspcTb.sv */
`default_nettype none

`include "lspc_settings.svh"

module lspcTb;
	timeunit 1ns;
	timeprecision 1ns;

	import lspcPkg::*;

	localparam int clkPeriod = 100;
	localparam int frameClks =
		`LSPC_CLKS_PER_PIXEL * `LSPC_PIXELS_PER_LINE * `LSPC_LINES_PER_FRAME;
	localparam int watchdogClks = 5 * frameClks + 10000;

	logic clk24M;
	logic rst;
	cpuReq_t cpuReq;
	word_t cpuRData;
	vramAddr_t vramAddr;
	word_t vramWData;
	logic vramWe;
	word_t vramRData;
	videoSync_t videoSync;
	iplLevel_t ipl;

	// 64K-word VRAM model
	word_t vram [0:65535];
	logic [31:0] lfsr;
	int errors;
	int testsPassed;
	int testsFailed;
	int errorMark;
	int assertMark;
	word_t rData;
	// Words written so far, for read-back
	vramAddr_t wrAddrs[$];
	word_t wrWords[$];

	lspcTop UUT (
		.clk24M    (clk24M),
		.rst       (rst),
		.cpuReq    (cpuReq),
		.cpuRData  (cpuRData),
		.vramAddr  (vramAddr),
		.vramWData (vramWData),
		.vramWe    (vramWe),
		.vramRData (vramRData),
		.videoSync (videoSync),
		.ipl       (ipl)
	);

	always #(clkPeriod / 2) clk24M = !clk24M;

	assign vramRData = vram[vramAddr];

	always @(posedge clk24M) begin
		if (vramWe)
			vram[vramAddr] <= vramWData;
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// One strobe cycle, then idle
	task automatic cpuWrite(input int index, input word_t data);
		@(posedge clk24M);
		#10;
		cpuReq = '{we: 1'b1, re: 1'b0, index: regIndex_t'(index), wData: data};
		@(posedge clk24M);
		#10;
		cpuReq = '0;
	endtask

	// Data is valid one cycle after the strobe
	task automatic cpuRead(input int index, output word_t data);
		@(posedge clk24M);
		#10;
		cpuReq = '{we: 1'b0, re: 1'b1, index: regIndex_t'(index), wData: '0};
		@(posedge clk24M);
		#10;
		cpuReq = '0;
		data = cpuRData;
	endtask

	task automatic checkValue(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic waitIpl(input string name, input iplLevel_t level, input int maxClks);
		int n;
		n = 0;
		while (ipl !== level && n < maxClks) begin
			@(posedge clk24M);
			#10;
			n++;
		end
		if (ipl !== level) begin
			errors++;
			$display("%s: ipl did not reach %0d within %0d clocks", name, level, maxClks);
		end
	endtask

	task automatic beginTest;
		errorMark = errors;
		assertMark = UUT.props.failCount;
	endtask

	task automatic endTest(input string name);
		if (errors == errorMark && UUT.props.failCount == assertMark) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: FAILED", name);
		end
	endtask

	// Writes with a stride of one, then a stride that wraps past the top
	task automatic vramWriteTest;
		vramAddr_t addr;
		word_t data;
		beginTest();
		addr = 16'h1234;
		cpuWrite(`LSPC_REG_VRAMMOD, 16'h0001);
		cpuWrite(`LSPC_REG_VRAMADDR, addr);
		repeat (4) begin
			data = word_t'(randBits(16));
			cpuWrite(`LSPC_REG_VRAMRW, data);
			wrAddrs.push_back(addr);
			wrWords.push_back(data);
			addr = addr + 16'h0001;
		end
		addr = 16'hffe0;
		cpuWrite(`LSPC_REG_VRAMMOD, 16'h0030);
		cpuWrite(`LSPC_REG_VRAMADDR, addr);
		repeat (3) begin
			data = word_t'(randBits(16));
			cpuWrite(`LSPC_REG_VRAMRW, data);
			wrAddrs.push_back(addr);
			wrWords.push_back(data);
			addr = addr + 16'h0030;
		end
		endTest("vramWrite");
	endtask

	task automatic vramReadTest;
		beginTest();
		for (int i = 0; i < wrAddrs.size(); i++) begin
			cpuWrite(`LSPC_REG_VRAMADDR, wrAddrs[i]);
			cpuRead(`LSPC_REG_VRAMRW, rData);
			checkValue("vramRead data", wrWords[i], rData);
		end
		// Untouched word from the preload
		cpuWrite(`LSPC_REG_VRAMADDR, 16'h8000);
		cpuRead(`LSPC_REG_VRAMRW, rData);
		checkValue("vramRead preload", vram[16'h8000], rData);
		cpuRead(`LSPC_REG_VRAMADDR, rData);
		checkValue("vramRead address", 16'h8000, rData);
		endTest("vramRead");
	endtask

	task automatic timerTest;
		int highClks;
		beginTest();
		// Load 100 while stopped, then start
		cpuWrite(`LSPC_REG_TIMERHIGH, 16'h0000);
		cpuWrite(`LSPC_REG_TIMERLOW, 16'd100);
		cpuWrite(`LSPC_REG_MODE, 16'h0010);
		waitIpl("timer", 2'd2, 101 * `LSPC_CLKS_PER_PIXEL + 40);
		cpuWrite(`LSPC_REG_MODE, 16'h0000);
		cpuWrite(`LSPC_REG_IRQACK, 16'h0002);
		repeat (3) @(posedge clk24M);
		#10;
		// Still far from line 240, so nothing else pending
		checkValue("timer ack ipl", 16'd0, {14'd0, ipl});
		highClks = 0;
		repeat (2000) begin
			@(posedge clk24M);
			#10;
			if (ipl == 2'd2)
				highClks++;
		end
		checkValue("timer disabled ipl2 clocks", 16'd0, word_t'(highClks));
		endTest("timer");
	endtask

	task automatic vblankTest;
		beginTest();
		waitIpl("vblank", 2'd1, frameClks + 1000);
		cpuRead(`LSPC_REG_MODE, rData);
		if (rData[15:7] < 9'd240 || rData[15:7] >= 9'd264) begin
			errors++;
			$display("[ERROR] vblank raster expected 240..263 actual %0d", rData[15:7]);
		end
		// Timer over a pending vblank, its ack drops back to level 1
		cpuWrite(`LSPC_REG_TIMERLOW, 16'd10);
		cpuWrite(`LSPC_REG_MODE, 16'h0010);
		waitIpl("vblank timer", 2'd2, 11 * `LSPC_CLKS_PER_PIXEL + 40);
		cpuWrite(`LSPC_REG_MODE, 16'h0000);
		cpuWrite(`LSPC_REG_IRQACK, 16'h0002);
		repeat (3) @(posedge clk24M);
		#10;
		checkValue("vblank timer ack ipl", 16'd1, {14'd0, ipl});
		cpuWrite(`LSPC_REG_IRQACK, 16'h0004);
		repeat (3) @(posedge clk24M);
		#10;
		checkValue("vblank ack ipl", 16'd0, {14'd0, ipl});
		endTest("vblank");
	endtask

	// Frame boundary seen through the vblank interrupt
	task automatic nextFrame;
		waitIpl("autoAnim", 2'd1, frameClks + 1000);
		cpuWrite(`LSPC_REG_IRQACK, 16'h0004);
	endtask

	task automatic animTest;
		aaCount_t aaExp;
		beginTest();
		// One frame at speed 0 since reset
		aaExp = 3'd1;
		cpuRead(`LSPC_REG_MODE, rData);
		checkValue("autoAnim start", 16'(aaExp), 16'(rData[2:0]));
		// Speed 0 steps every frame
		nextFrame();
		aaExp = aaExp + 3'd1;
		cpuRead(`LSPC_REG_MODE, rData);
		checkValue("autoAnim speed0", 16'(aaExp), 16'(rData[2:0]));
		// Speed 1 steps every second frame
		cpuWrite(`LSPC_REG_MODE, 16'h0100);
		nextFrame();
		cpuRead(`LSPC_REG_MODE, rData);
		checkValue("autoAnim speed1 hold", 16'(aaExp), 16'(rData[2:0]));
		nextFrame();
		aaExp = aaExp + 3'd1;
		cpuRead(`LSPC_REG_MODE, rData);
		checkValue("autoAnim speed1 step", 16'(aaExp), 16'(rData[2:0]));
		endTest("autoAnim");
	endtask

	// Runs through one full vsync pulse, checked by the bound assertions
	task automatic syncTest;
		int n;
		logic seenLow;
		beginTest();
		n = 0;
		seenLow = 1'b0;
		while (!(seenLow && videoSync.vsync) && n < frameClks) begin
			@(posedge clk24M);
			#10;
			n++;
			if (!videoSync.vsync)
				seenLow = 1'b1;
		end
		if (!(seenLow && videoSync.vsync)) begin
			errors++;
			$display("sync: no complete vsync pulse within one frame");
		end
		repeat (2) @(posedge clk24M);
		endTest("sync");
	endtask

	initial begin
		clk24M = 1'b0;
		rst = 1'b1;
		cpuReq = '0;
		lfsr = 32'h59d6;
		errors = 0;
		testsPassed = 0;
		testsFailed = 0;
		for (int a = 0; a < 65536; a++)
			vram[a] = word_t'(randBits(16));
		repeat (5) @(posedge clk24M);
		#10;
		rst = 1'b0;
		vramWriteTest();
		vramReadTest();
		timerTest();
		vblankTest();
		animTest();
		syncTest();
		$display("tests passed %0d failed %0d, assertion failures %0d",
			testsPassed, testsFailed, UUT.props.failCount);
		if (testsFailed == 0 && errors == 0 && UUT.props.failCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Five frames plus slack covers every test
	initial begin
		repeat (watchdogClks) @(posedge clk24M);
		$display("watchdog: run exceeded %0d clocks", watchdogClks);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/lspcPkg.sv
source/videoTiming.sv
source/cpuRegs.sv
source/rasterTimer.sv
source/irqControl.sv
source/autoAnim.sv
source/lspcTop.sv
bench/lspc_properties.sv
bench/lspcTb.sv

/* Bender.yml */
package:
  name: lspc

sources:
  - include_dirs:
      - source
    files:
      - source/lspcPkg.sv
      - source/videoTiming.sv
      - source/cpuRegs.sv
      - source/rasterTimer.sv
      - source/irqControl.sv
      - source/autoAnim.sv
      - source/lspcTop.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/lspc_properties.sv
      - bench/lspcTb.sv
